// File: hdl/decode_top.sv
/*
 * decode_top
 * decode slice: fetch tagging, instruction queue and control decode,
 * credit flow control on both the input and output side
 */
`timescale 1ns/1ps

module decode_top #(
   parameter int QUEUE_DEPTH = 4,   // also the sender's starting credits
   parameter int OUT_CREDITS = 2
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  isa_pkg::instr_u      in_instr,
   output logic                 in_credit,
   output logic                 halted,
   output logic                 out_valid,
   output pipe_pkg::ctrl_word_t out_ctrl,
   input  logic                 out_credit
);

   logic                  push_valid;
   pipe_pkg::fetch_item_t push_item;
   logic                  pop_credit;
   logic                  q_valid;
   pipe_pkg::fetch_item_t q_item;
   logic                  q_pop;

   fetch_unit fetch0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_instr   (in_instr),
      .in_credit  (in_credit),
      .halted     (halted),
      .push_valid (push_valid),
      .push_item  (push_item),
      .pop_credit (pop_credit)
   );

   instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (push_valid),
      .push_item  (push_item),
      .q_valid    (q_valid),
      .q_item     (q_item),
      .q_pop      (q_pop),
      .pop_credit (pop_credit)
   );

   decode_unit #(.OUT_CREDITS(OUT_CREDITS)) decode0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .q_valid    (q_valid),
      .q_item     (q_item),
      .q_pop      (q_pop),
      .out_valid  (out_valid),
      .out_ctrl   (out_ctrl),
      .out_credit (out_credit)
   );

endmodule

// File: hdl/decode_unit.sv
/*
 * decode_unit
 * control unit stage: decodes the queue head into a registered control
 * word and spends one output credit per word sent downstream
 */
`timescale 1ns/1ps

module decode_unit #(
   parameter int OUT_CREDITS = 2
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  q_valid,
   input  pipe_pkg::fetch_item_t q_item,
   output logic                  q_pop,
   output logic                  out_valid,
   output pipe_pkg::ctrl_word_t  out_ctrl,
   input  logic                  out_credit
);

   localparam int CW = $clog2(OUT_CREDITS + 1);

   isa_pkg::instr_u      ins;
   isa_pkg::opcode_t     op;
   isa_pkg::funct_t      fn;
   pipe_pkg::ctrl_word_t dec;        // combinational decode of the head
   logic [CW-1:0]        credits;    // free slots downstream

   assign ins = q_item.instr;
   assign op  = ins.r.opcode;
   assign fn  = ins.r.funct;

   // credit is taken at the pop, out_valid follows a cycle later
   assign q_pop = q_valid && (credits != '0);

   always_comb begin
      dec       = '0;
      dec.pc    = q_item.pc;
      dec.rs    = ins.r.rs;
      dec.rt    = ins.r.rt;
      dec.rd    = ins.r.rd;
      dec.shamt = ins.r.shamt;
      dec.halt  = (op == isa_pkg::HALT);

      case (op)
         isa_pkg::RTYPE: dec.regdst = pipe_pkg::RD_RD;
         isa_pkg::JAL:   dec.regdst = pipe_pkg::RD_RA;
         default:        dec.regdst = pipe_pkg::RD_RT;
      endcase

      // logic ops and lui take the immediate unsigned
      dec.extop = !(op == isa_pkg::ORI || op == isa_pkg::ANDI ||
                    op == isa_pkg::XORI || op == isa_pkg::LUI);

      case (op)
         isa_pkg::LUI: dec.alusrc = pipe_pkg::SRC_LUI;
         isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::ORI, isa_pkg::ANDI, isa_pkg::XORI,
         isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU, isa_pkg::SW, isa_pkg::SC,
         isa_pkg::LW:  dec.alusrc = pipe_pkg::SRC_IMM;
         default:      dec.alusrc = pipe_pkg::SRC_REG;   // rtype and the rest
      endcase

      case (op)
         isa_pkg::J, isa_pkg::JAL: dec.pcsel = pipe_pkg::PC_JUMP;
         isa_pkg::BEQ:             dec.pcsel = pipe_pkg::PC_BEQ;
         isa_pkg::BNE:             dec.pcsel = pipe_pkg::PC_BNE;
         isa_pkg::RTYPE:           dec.pcsel = (fn == isa_pkg::JR) ? pipe_pkg::PC_JUMP
                                                                   : pipe_pkg::PC_NEXT;
         default:                  dec.pcsel = pipe_pkg::PC_NEXT;
      endcase

      dec.memwr = (op == isa_pkg::SW);

      case (op)
         isa_pkg::JAL: dec.wbsel = pipe_pkg::WB_LINK;
         isa_pkg::LW:  dec.wbsel = pipe_pkg::WB_MEM;
         default:      dec.wbsel = pipe_pkg::WB_ALU;
      endcase

      dec.regwr   = !(op == isa_pkg::SW || op == isa_pkg::BEQ || op == isa_pkg::BNE ||
                      op == isa_pkg::SC || op == isa_pkg::J);
      dec.icu_ren = !(op == isa_pkg::SW || op == isa_pkg::LW);
      dec.dcu_ren = (op == isa_pkg::LW);

      if (op == isa_pkg::RTYPE) begin
         case (fn)
            isa_pkg::ADD, isa_pkg::ADDU: dec.alu_op = isa_pkg::ALU_ADD;
            isa_pkg::SUB, isa_pkg::SUBU: dec.alu_op = isa_pkg::ALU_SUB;
            isa_pkg::AND:  dec.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OR:   dec.alu_op = isa_pkg::ALU_OR;
            isa_pkg::XOR:  dec.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::NOR:  dec.alu_op = isa_pkg::ALU_NOR;
            isa_pkg::SLL:  dec.alu_op = isa_pkg::ALU_SLL;
            isa_pkg::SRL:  dec.alu_op = isa_pkg::ALU_SRL;
            isa_pkg::SLT:  dec.alu_op = isa_pkg::ALU_SLT;
            isa_pkg::SLTU: dec.alu_op = isa_pkg::ALU_SLTU;
            default:       dec.alu_op = isa_pkg::ALU_ADD;   // jr and unknowns
         endcase
      end else begin
         case (op)
            isa_pkg::ORI:             dec.alu_op = isa_pkg::ALU_OR;
            isa_pkg::ANDI:            dec.alu_op = isa_pkg::ALU_AND;
            isa_pkg::XORI:            dec.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::SLTI:            dec.alu_op = isa_pkg::ALU_SLT;
            isa_pkg::SLTIU:           dec.alu_op = isa_pkg::ALU_SLTU;
            isa_pkg::BEQ, isa_pkg::BNE: dec.alu_op = isa_pkg::ALU_SUB;  // compare by subtract
            default:                  dec.alu_op = isa_pkg::ALU_ADD;   // address calc
         endcase
      end

      // immediate, lui first since its extop is zero too
      if (dec.alusrc == pipe_pkg::SRC_LUI)
         dec.imm32 = {ins.i.imm, 16'h0000};
      else if (dec.extop)
         dec.imm32 = {{16{ins.i.imm[15]}}, ins.i.imm};
      else
         dec.imm32 = {16'h0000, ins.i.imm};
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         credits   <= CW'(OUT_CREDITS);
      end else begin
         out_valid <= q_pop;
         case ({out_credit, q_pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: ;   // return and spend cancel
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (q_pop)
         out_ctrl <= dec;   // held until the next pop
   end

endmodule

// File: hdl/fetch_unit.sv
/*
 * fetch_unit
 * tags incoming instruction words with a word PC and pushes them to the
 * queue; goes quiet after a HALT but keeps handing credits back
 */
`timescale 1ns/1ps

module fetch_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  isa_pkg::instr_u       in_instr,
   output logic                  in_credit,
   output logic                  halted,
   output logic                  push_valid,
   output pipe_pkg::fetch_item_t push_item,
   input  logic                  pop_credit
);

   logic [29:0] pc_cnt;   // next PC to hand out
   logic        take;     // word accepted this cycle
   logic        drop;     // word arrived after halt
   logic [7:0]  owed;     // credits still waiting for a return slot
   logic [8:0]  due;

   assign take = in_valid && !halted;
   assign drop = in_valid && halted;

   // a pop and a dropped word can land together; one goes out now, the rest wait
   assign due = 9'(owed) + 9'(pop_credit) + 9'(drop);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_cnt     <= '0;
         halted     <= 1'b0;
         push_valid <= 1'b0;
         in_credit  <= 1'b0;
         owed       <= '0;
      end else begin
         push_valid <= take;
         in_credit  <= (due != 9'd0);
         owed       <= (due != 9'd0) ? 8'(due - 9'd1) : 8'd0;
         if (take) begin
            pc_cnt <= pc_cnt + 30'd1;
            if (in_instr.r.opcode == isa_pkg::HALT)
               halted <= 1'b1;   // sticky until reset
         end
      end
   end

   // payload, qualified by push_valid
   always_ff @(posedge clk) begin
      if (take) begin
         push_item.pc    <= pc_cnt;
         push_item.instr <= in_instr;
      end
   end

endmodule

// File: hdl/instr_queue.sv
/*
 * instr_queue
 * circular FIFO between fetch and decode; sized by QUEUE_DEPTH and kept
 * from overflowing by the sender's credits, one credit back per pop
 */
`timescale 1ns/1ps

module instr_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push_valid,
   input  pipe_pkg::fetch_item_t push_item,
   output logic                  q_valid,
   output pipe_pkg::fetch_item_t q_item,
   input  logic                  q_pop,
   output logic                  pop_credit
);

   localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CW = $clog2(QUEUE_DEPTH + 1);
   localparam logic [AW-1:0] LAST = AW'(QUEUE_DEPTH - 1);

   pipe_pkg::fetch_item_t mem [QUEUE_DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;   // occupancy
   logic          pop;

   assign pop     = q_pop && q_valid;   // ignore a pop on empty
   assign q_valid = (count != '0);
   assign q_item  = mem[rd_ptr];        // head shown directly

   always_ff @(posedge clk) begin
      if (push_valid)
         mem[wr_ptr] <= push_item;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         pop_credit <= 1'b0;
      end else begin
         pop_credit <= pop;   // one pulse per pop, one cycle late
         if (push_valid)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         case ({push_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // both or neither, no change
         endcase
      end
   end

endmodule

// File: hdl/isa_pkg.sv
/*
 * isa_pkg
 * instruction set encodings for the decode slice: opcodes, R-type functs,
 * ALU operations and the three field layouts of a 32-bit word
 */
package isa_pkg;

   // primary opcode, bits 31:26
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      J     = 6'h02,
      JAL   = 6'h03,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      SLTI  = 6'h0a,
      SLTIU = 6'h0b,
      ANDI  = 6'h0c,
      ORI   = 6'h0d,
      XORI  = 6'h0e,
      LUI   = 6'h0f,
      LW    = 6'h23,
      SW    = 6'h2b,
      LL    = 6'h30,
      SC    = 6'h38,
      HALT  = 6'h3f   // all ones, stops fetch
   } opcode_t;

   // funct field, only meaningful under RTYPE
   typedef enum logic [5:0] {
      SLL  = 6'h00,
      SRL  = 6'h02,
      JR   = 6'h08,
      ADD  = 6'h20,
      ADDU = 6'h21,
      SUB  = 6'h22,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      XOR  = 6'h26,
      NOR  = 6'h27,
      SLT  = 6'h2a,
      SLTU = 6'h2b
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU
   } alu_op_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_t     funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } i_fmt_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [25:0] addr;   // word target, low bits of the jump
   } j_fmt_t;

   // one word, three views; the opcode sits in the same place in all of them
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

endpackage

// File: hdl/pipe_pkg.sv
/*
 * pipe_pkg
 * pipeline records between fetch, queue and decode, plus the select
 * encodings carried in the decoded control word
 */
package pipe_pkg;

   // write register select
   typedef enum logic [1:0] {
      RD_RD = 2'd0,   // R-type destination
      RD_RT = 2'd1,   // immediates and loads
      RD_RA = 2'd2    // link register for jal
   } regdst_t;

   // second ALU operand
   typedef enum logic [1:0] {
      SRC_REG = 2'd0,
      SRC_IMM = 2'd1,
      SRC_LUI = 2'd2
   } alusrc_t;

   // branch or jump kind, resolved later in the core
   typedef enum logic [1:0] {
      PC_NEXT = 2'd0,
      PC_BEQ  = 2'd1,
      PC_BNE  = 2'd2,
      PC_JUMP = 2'd3
   } pcsel_t;

   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_MEM  = 2'd1,
      WB_LINK = 2'd2   // pc + 1 into ra
   } wbsel_t;

   typedef struct packed {
      logic [29:0]      pc;      // word address
      isa_pkg::instr_u  instr;
   } fetch_item_t;

   typedef struct packed {
      logic [29:0]      pc;
      logic [4:0]       rs;
      logic [4:0]       rt;
      logic [4:0]       rd;
      logic [4:0]       shamt;
      logic [31:0]      imm32;   // finished immediate
      regdst_t          regdst;
      logic             extop;   // 1 sign, 0 zero extend
      alusrc_t          alusrc;
      pcsel_t           pcsel;
      logic             memwr;
      wbsel_t           wbsel;
      logic             regwr;
      logic             icu_ren;
      logic             dcu_ren;
      isa_pkg::alu_op_t alu_op;
      logic             halt;
   } ctrl_word_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the decode slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --no-stop-fail -Wno-fatal \
   --top-module decode_tb -f vlog.f -Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: verif/decode_assertions.sv
/*
 * decode_assertions
 * concurrent checks on the control decode stage bound into decode_unit
 * covering field copy, control rules, immediate forming and output credits
 */
`timescale 1ns/1ps

module decode_assertions #(
   parameter int OUT_CREDITS = 2
) (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  q_pop,
   input pipe_pkg::fetch_item_t q_item,
   input logic                  out_valid,
   input pipe_pkg::ctrl_word_t  out_ctrl,
   input logic                  out_credit
);

   int                 fails = 0;   // failed checks so far
   int                 avail;       // output credits as the outside sees them
   isa_pkg::instr_u    w;           // word behind the next out_ctrl
   logic [29:0]        w_pc;        // pc of that word
   isa_pkg::opcode_t   op;
   isa_pkg::alu_op_t   exp_alu;
   pipe_pkg::regdst_t  exp_regdst;
   pipe_pkg::alusrc_t  exp_alusrc;
   pipe_pkg::pcsel_t   exp_pcsel;
   pipe_pkg::wbsel_t   exp_wbsel;
   logic [31:0]        exp_imm;
   logic               exp_regwr;

   always_ff @(posedge clk) begin
      if (q_pop) begin
         w    <= q_item.instr;
         w_pc <= q_item.pc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         avail <= OUT_CREDITS;
      else
         avail <= avail + int'(out_credit) - int'(out_valid);
   end

   always_comb begin
      op        = w.r.opcode;
      exp_regwr = !(op inside {isa_pkg::SW, isa_pkg::BEQ, isa_pkg::BNE,
                               isa_pkg::SC, isa_pkg::J});
      exp_regdst = (op == isa_pkg::RTYPE) ? pipe_pkg::RD_RD :
                   (op == isa_pkg::JAL)   ? pipe_pkg::RD_RA : pipe_pkg::RD_RT;
      exp_wbsel  = (op == isa_pkg::LW)  ? pipe_pkg::WB_MEM :
                   (op == isa_pkg::JAL) ? pipe_pkg::WB_LINK : pipe_pkg::WB_ALU;
      if (op == isa_pkg::LUI)
         exp_alusrc = pipe_pkg::SRC_LUI;
      else if (op inside {isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU, isa_pkg::ANDI,
                          isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LW, isa_pkg::SW,
                          isa_pkg::SC, isa_pkg::BEQ, isa_pkg::BNE})
         exp_alusrc = pipe_pkg::SRC_IMM;
      else
         exp_alusrc = pipe_pkg::SRC_REG;
      // branch kind only with no taken bit
      exp_pcsel = pipe_pkg::PC_NEXT;
      if (op == isa_pkg::BEQ)
         exp_pcsel = pipe_pkg::PC_BEQ;
      if (op == isa_pkg::BNE)
         exp_pcsel = pipe_pkg::PC_BNE;
      if (op inside {isa_pkg::J, isa_pkg::JAL} ||
          (op == isa_pkg::RTYPE && w.r.funct == isa_pkg::JR))
         exp_pcsel = pipe_pkg::PC_JUMP;
      case (op)
         isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI: exp_imm = {16'h0000, w.i.imm};
         isa_pkg::LUI:                              exp_imm = {w.i.imm, 16'h0000};
         default: exp_imm = {{16{w.i.imm[15]}}, w.i.imm};
      endcase
      // funct for rtype, opcode for the rest
      exp_alu = isa_pkg::ALU_ADD;
      if (op == isa_pkg::RTYPE) begin
         case (w.r.funct)
            isa_pkg::SUB, isa_pkg::SUBU: exp_alu = isa_pkg::ALU_SUB;
            isa_pkg::AND:  exp_alu = isa_pkg::ALU_AND;
            isa_pkg::OR:   exp_alu = isa_pkg::ALU_OR;
            isa_pkg::XOR:  exp_alu = isa_pkg::ALU_XOR;
            isa_pkg::NOR:  exp_alu = isa_pkg::ALU_NOR;
            isa_pkg::SLL:  exp_alu = isa_pkg::ALU_SLL;
            isa_pkg::SRL:  exp_alu = isa_pkg::ALU_SRL;
            isa_pkg::SLT:  exp_alu = isa_pkg::ALU_SLT;
            isa_pkg::SLTU: exp_alu = isa_pkg::ALU_SLTU;
            default: ;     // add, addu and jr
         endcase
      end else if (op inside {isa_pkg::BEQ, isa_pkg::BNE}) begin
         exp_alu = isa_pkg::ALU_SUB;
      end else if (op == isa_pkg::ANDI) begin
         exp_alu = isa_pkg::ALU_AND;
      end else if (op == isa_pkg::ORI) begin
         exp_alu = isa_pkg::ALU_OR;
      end else if (op == isa_pkg::XORI) begin
         exp_alu = isa_pkg::ALU_XOR;
      end else if (op == isa_pkg::SLTI) begin
         exp_alu = isa_pkg::ALU_SLT;
      end else if (op == isa_pkg::SLTIU) begin
         exp_alu = isa_pkg::ALU_SLTU;
      end
   end

   // fields copied straight from the popped word
   a_fields: assert property (@(posedge clk) disable iff (!rst_n)
      q_pop |=> out_valid && out_ctrl.pc == $past(q_item.pc)
         && out_ctrl.rs == $past(q_item.instr.r.rs) && out_ctrl.rt == $past(q_item.instr.r.rt)
         && out_ctrl.rd == $past(q_item.instr.r.rd)
         && out_ctrl.shamt == $past(q_item.instr.r.shamt))
      else begin
         fails++;
         $error("CHECK FAILED t=%0t out_ctrl.pc expected %0d got %0d", $time,
                $sampled(w_pc), $sampled(out_ctrl.pc));
      end

   // lui leaves extop free, the logic immediates take it unsigned
   a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> out_ctrl.regwr == exp_regwr && out_ctrl.regdst == exp_regdst
         && out_ctrl.alusrc == exp_alusrc && out_ctrl.pcsel == exp_pcsel
         && out_ctrl.wbsel == exp_wbsel && out_ctrl.memwr == (op == isa_pkg::SW)
         && (op == isa_pkg::LUI
             || out_ctrl.extop == !(op inside {isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI}))
         && out_ctrl.dcu_ren == (op == isa_pkg::LW)
         && out_ctrl.icu_ren == !(op inside {isa_pkg::LW, isa_pkg::SW})
         && out_ctrl.halt == (op == isa_pkg::HALT))
      else begin
         fails++;
         $error("CHECK FAILED t=%0t out_ctrl controls for opcode %h got %h", $time,
                $sampled(op), $sampled(out_ctrl));
      end

   a_alu: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> out_ctrl.alu_op == exp_alu)
      else begin
         fails++;
         $error("CHECK FAILED t=%0t out_ctrl.alu_op expected %0d got %0d", $time,
                $sampled(exp_alu), $sampled(out_ctrl.alu_op));
      end

   a_imm: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> out_ctrl.imm32 == exp_imm)
      else begin
         fails++;
         $error("CHECK FAILED t=%0t out_ctrl.imm32 expected %h got %h", $time,
                $sampled(exp_imm), $sampled(out_ctrl.imm32));
      end

   // never fire into a full consumer
   a_credit: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> avail > 0)
      else begin
         fails++;
         $error("out_valid fired with no output credit left at t=%0t", $time);
      end

endmodule

// File: verif/decode_tb.sv
/*
 * decode_tb
 * random instruction stream into the decode slice with credits on both
 * sides; checks output order, HALT and input credits, decode rules sit
 * in the bound assertions
 */
`timescale 1ns/1ps

module decode_tb;

   localparam int QUEUE_DEPTH = 4;
   localparam int OUT_CREDITS = 2;
   localparam int N_INSTR     = 300;              // words before the HALT
   localparam int N_TOTAL     = N_INSTR + 1 + 4;  // halt, then four that get dropped
   localparam int MAX_CYCLES  = 10 * N_TOTAL + 200;

   localparam isa_pkg::opcode_t OPS [16] = '{
      isa_pkg::RTYPE, isa_pkg::J, isa_pkg::JAL, isa_pkg::BEQ, isa_pkg::BNE,
      isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU, isa_pkg::ANDI, isa_pkg::ORI,
      isa_pkg::XORI, isa_pkg::LUI, isa_pkg::LW, isa_pkg::SW, isa_pkg::LL, isa_pkg::SC
   };
   localparam isa_pkg::funct_t FUNCTS [13] = '{
      isa_pkg::SLL, isa_pkg::SRL, isa_pkg::JR, isa_pkg::ADD, isa_pkg::ADDU,
      isa_pkg::SUB, isa_pkg::SUBU, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR,
      isa_pkg::NOR, isa_pkg::SLT, isa_pkg::SLTU
   };

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic                 in_valid;
   isa_pkg::instr_u      in_instr;
   logic                 in_credit;
   logic                 halted;
   logic                 out_valid;
   pipe_pkg::ctrl_word_t out_ctrl;
   logic                 out_credit;

   logic [31:0]     lcg       = 32'h8f6906ee;
   logic [31:0]     r;
   isa_pkg::instr_u word;
   int              errors    = 0;
   int              cycles    = 0;
   int              credits   = QUEUE_DEPTH;  // input side, ours to spend
   int              owed      = 0;            // outputs not yet handed back
   int              sent      = 0;
   int              drain     = 0;            // quiet cycles after the end
   logic [29:0]     exp_pc    = '0;
   bit              halt_seen = 1'b0;
   bit              bursty    = 1'b0;
   bit              flushing  = 1'b0;

   decode_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_instr   (in_instr),
      .in_credit  (in_credit),
      .halted     (halted),
      .out_valid  (out_valid),
      .out_ctrl   (out_ctrl),
      .out_credit (out_credit)
   );

   bind decode_unit decode_assertions #(.OUT_CREDITS(OUT_CREDITS)) chk0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .q_pop      (q_pop),
      .q_item     (q_item),
      .out_valid  (out_valid),
      .out_ctrl   (out_ctrl),
      .out_credit (out_credit)
   );

   always #2 clk = ~clk;   // 4 ns period

   function automatic logic [31:0] rand32();
      lcg = lcg * 32'd1664525 + 32'd1013904223;
      return lcg;
   endfunction

   // legal opcode, random fields, legal funct under rtype
   function automatic isa_pkg::instr_u random_instr();
      isa_pkg::instr_u w;
      logic [31:0]     pick;
      pick       = rand32();
      w          = rand32();
      w.r.opcode = OPS[pick[3:0]];
      if (w.r.opcode == isa_pkg::RTYPE)
         w.r.funct = FUNCTS[int'(pick[11:8]) % 13];
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("ERROR t=%0t %s", $time, what);
   endtask

   initial begin
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_instr   = '0;
      out_credit = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      while (drain < 20) begin
         @(posedge clk);
         r = rand32();
         if (in_credit)
            credits++;
         if (credits > QUEUE_DEPTH)
            note_failure("input credits returned beyond the queue depth");
         if (out_valid) begin
            if (halt_seen)
               note_failure("an output followed the HALT");
            check_value("out_ctrl.pc", 32'(exp_pc), 32'(out_ctrl.pc));
            exp_pc = exp_pc + 30'd1;
            if (out_ctrl.halt)
               halt_seen = 1'b1;
            owed++;
         end
         // next word when a credit is held, with idle gaps
         if (sent < N_TOTAL && credits > 0 && r[2:0] != 3'd0) begin
            word = random_instr();
            if (sent == N_INSTR)
               word.r.opcode = isa_pkg::HALT;
            in_valid <= 1'b1;
            in_instr <= word;
            credits--;
            sent++;
         end else begin
            in_valid <= 1'b0;
         end
         // output credits trickle back, or are held and returned in a burst
         if (r[31:27] == 5'd0)
            bursty = !bursty;
         if (owed == OUT_CREDITS)
            flushing = 1'b1;
         if (owed == 0)
            flushing = 1'b0;
         if (owed > 0 && (bursty ? flushing : r[5:4] == 2'd0)) begin
            out_credit <= 1'b1;
            owed--;
         end else begin
            out_credit <= 1'b0;
         end
         if (sent == N_TOTAL && halt_seen && credits == QUEUE_DEPTH)
            drain++;
      end
      check_value("out_valid count", 32'(N_INSTR + 1), 32'(exp_pc));
      if (!halted)
         note_failure("halted flag is low after the HALT");
      $display("closing: %0d testbench errors, %0d assertion failures",
               errors, dut0.decode0.chk0.fails);
      if (errors == 0 && dut0.decode0.chk0.fails == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout after %0d cycles, the stream never drained", cycles);
         $display("closing: %0d testbench errors, %0d assertion failures",
                  errors, dut0.decode0.chk0.fails);
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

// File: vlog.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/decode_unit.sv
hdl/decode_top.sv
verif/decode_assertions.sv
verif/decode_tb.sv
